// ==== list.f ====
source/mul_pkg.sv
source/cmd_queue.sv
source/mul_shift_add.sv
source/mul_unit.sv
source/result_port.sv
source/mul_csr.sv
source/mul_coproc_top.sv
verification/tb_mul_coproc.sv

// ==== Makefile ====
# Verilator build and run of the multiply coprocessor testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mul_coproc \
		-f list.f -Mdir obj_dir -o tb_mul_coproc

run: compile
	@out="$$(./obj_dir/tb_mul_coproc)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^No errors$$'

clean:
	rm -rf obj_dir

// ==== verification/tb_mul_coproc.sv ====
// testbench for the multiply coprocessor, random commands checked against a reference model
`timescale 1ns/1ps

module tb_mul_coproc import mul_pkg::*; ();

    localparam int data_width     = 16;
    localparam int queue_depth    = 4;
    localparam int rsp_credits    = 2;
    localparam int num_cmds       = 200;
    localparam int timeout_cycles = num_cmds * (data_width + 8) + 2000;

    logic                        clk = 1'b0;
    logic                        reset;
    logic                        cmd_push;
    logic [op_width-1:0]         cmd_op;
    logic [data_width-1:0]       cmd_a;
    logic [data_width-1:0]       cmd_b;
    logic                        cmd_credit;
    logic                        rsp_valid;
    logic [data_width-1:0]       rsp_data;
    logic                        rsp_credit;
    logic                        csr_write;
    logic                        csr_read;
    logic [csr_addr_width-1:0]   csr_addr;
    logic [data_width-1:0]       csr_wdata;
    logic [data_width-1:0]       csr_rdata;

    // host, consumer and model state, only touched on the falling edge
    logic [data_width-1:0]       exp_q [$];
    logic [data_width-1:0]       exp_front = '0;
    logic                        exp_have = 1'b0;
    logic                        was_rsp_valid = 1'b0;
    logic                        was_cmd_credit = 1'b0;
    logic                        disabled = 1'b0;
    logic [data_width-1:0]       count_model = '0;
    int                          host_credits = queue_depth;
    int                          rsp_held = rsp_credits;
    int                          owed = 0;
    int                          hold_cycles = 0;
    int                          pushes = 0;
    int                          credit_pulses = 0;
    int                          results = 0;
    int                          reads = 0;
    int                          errors = 0;
    int                          cycles = 0;
    string                       test_name = "reset";

    mul_coproc_top #(
        .data_width  (data_width),
        .queue_depth (queue_depth),
        .rsp_credits (rsp_credits)
    ) i_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, %0d results never arrived", cycles, exp_q.size());
            $display("Errors found");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // checks on the rising edge
    // ------------------------------------------------------------------------

    data_matches: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> (exp_have && rsp_data == exp_front))
        else begin
            errors++;
            $display("error %s: expected %h, actual %h", test_name, exp_front, $sampled(rsp_data));
        end

    credit_held: assert property (@(posedge clk) disable iff (reset) rsp_valid |-> rsp_held != 0)
        else begin
            errors++;
            $display("error %s: result sent while the consumer granted no credit", test_name);
        end

    quiet_before_commands: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> pushes != 0)
        else begin
            errors++;
            $display("error %s: result sent before any command was pushed", test_name);
        end

    quiet_while_disabled: assert property (@(posedge clk) disable iff (reset)
        disabled |-> !rsp_valid)
        else begin
            errors++;
            $display("error %s: result sent while the coprocessor was disabled", test_name);
        end

    credits_bounded: assert property (@(posedge clk) disable iff (reset)
        cmd_credit |-> credit_pulses < pushes)
        else begin
            errors++;
            $display("error %s: more command credits returned than commands pushed", test_name);
        end

    // ------------------------------------------------------------------------
    // reference model and host tasks
    // ------------------------------------------------------------------------

    function automatic logic [data_width-1:0] model_result(
        input logic [op_width-1:0]   op,
        input logic [data_width-1:0] a,
        input logic [data_width-1:0] b
    );
        logic [2*data_width-1:0] wide_a;
        logic [2*data_width-1:0] wide_b;
        logic [2*data_width-1:0] full;
        if (op[op_signed_bit]) begin
            wide_a = {{data_width{a[data_width-1]}}, a};
            wide_b = {{data_width{b[data_width-1]}}, b};
        end else begin
            wide_a = {{data_width{1'b0}}, a};
            wide_b = {{data_width{1'b0}}, b};
        end
        // sign extended to full width, so the low half of this product is exact
        full = wide_a * wide_b;
        if (op[op_high_bit]) begin
            return full[2*data_width-1:data_width];
        end
        return full[data_width-1:0];
    endfunction

    // settle the cycle just finished, then clear the pulse inputs
    task automatic next_cycle();
        @(negedge clk);
        if (was_rsp_valid) begin
            if (exp_q.size() != 0) begin
                exp_q.delete(0);
            end
            rsp_held--;
            owed++;
            results++;
            count_model++;
        end
        if (was_cmd_credit) begin
            host_credits++;
            credit_pulses++;
        end
        if (rsp_credit) begin
            rsp_held++;
        end
        exp_have       = exp_q.size() != 0;
        exp_front      = exp_have ? exp_q[0] : '0;
        was_rsp_valid  = rsp_valid;
        was_cmd_credit = cmd_credit;
        cmd_push       = 1'b0;
        csr_write      = 1'b0;
        csr_read       = 1'b0;
        rsp_credit     = 1'b0;
        // consumer returns credits late and now and then holds them back
        if (hold_cycles != 0) begin
            hold_cycles--;
        end else if ($urandom % 50 == 0) begin
            hold_cycles = $urandom % 40;
        end else if (owed != 0 && $urandom % 3 != 0) begin
            rsp_credit = 1'b1;
            owed--;
        end
    endtask

    task automatic push_cmd(
        input logic [op_width-1:0]   op,
        input logic [data_width-1:0] a,
        input logic [data_width-1:0] b
    );
        while (host_credits == 0) begin
            next_cycle();
        end
        cmd_push = 1'b1;
        cmd_op   = op;
        cmd_a    = a;
        cmd_b    = b;
        host_credits--;
        pushes++;
        exp_q.push_back(model_result(op, a, b));
        next_cycle();
    endtask

    task automatic write_ctrl(input logic [data_width-1:0] value);
        csr_write = 1'b1;
        csr_addr  = csr_ctrl_addr;
        csr_wdata = value;
        next_cycle();
    endtask

    task automatic check_read(
        input logic [csr_addr_width-1:0] addr,
        input logic [data_width-1:0]     expected,
        input string                     name
    );
        csr_read = 1'b1;
        csr_addr = addr;
        next_cycle();
        reads++;
        read_matches: assert (csr_rdata == expected) else begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, csr_rdata);
        end
    endtask

    task automatic drain();
        hold_cycles = 0;
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (4) next_cycle();
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin
        logic [data_width-1:0] corner [6];
        logic [op_width-1:0]   op;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        reset      = 1'b1;
        cmd_push   = 1'b0;
        cmd_op     = '0;
        cmd_a      = '0;
        cmd_b      = '0;
        rsp_credit = 1'b0;
        csr_write  = 1'b0;
        csr_read   = 1'b0;
        csr_addr   = '0;
        csr_wdata  = '0;
        void'($urandom(12921));
        corner[0] = '0;
        corner[1] = data_width'(1);
        corner[2] = {1'b1, {(data_width-1){1'b0}}};
        corner[3] = {1'b0, {(data_width-1){1'b1}}};
        corner[4] = '1;
        corner[5] = data_width'($urandom);
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_name = "idle after reset";
        repeat (8) next_cycle();
        write_ctrl(data_width'(1));

        // zero, one, most negative, most positive and all ones in each op code
        test_name = "corner operands";
        for (int o = 0; o < 4; o++) begin
            for (int i = 0; i < 6; i++) begin
                push_cmd(op_width'(o), corner[i], corner[i]);
                push_cmd(op_width'(o), corner[i], corner[(i + 2) % 6]);
            end
        end

        test_name = "random traffic";
        for (int n = 0; n < 140; n++) begin
            op = op_width'($urandom % 4);
            a  = data_width'($urandom);
            b  = data_width'($urandom) >> ($urandom % data_width);
            if ($urandom % 16 == 0) begin
                a = '0;
            end
            push_cmd(op, a, b);
            if ($urandom % 4 == 0) begin
                next_cycle();
            end
        end
        drain();
        check_read(csr_count_addr, count_model, "count after traffic");
        write_ctrl(data_width'(3));
        count_model = '0;
        check_read(csr_count_addr, count_model, "count after clear");

        test_name = "enable off";
        write_ctrl(data_width'(0));
        disabled = 1'b1;
        for (int n = 0; n < queue_depth; n++) begin
            push_cmd(op_width'($urandom % 4), data_width'($urandom), data_width'($urandom));
        end
        repeat (24) next_cycle();
        check_read(csr_level_addr, data_width'(queue_depth), "level while disabled");
        disabled = 1'b0;
        write_ctrl(data_width'(1));
        drain();
        check_read(csr_count_addr, count_model, "count after enable");

        test_name = "final drain";
        host_credits_back: assert (host_credits == queue_depth) else begin
            errors++;
            $display("error %s: expected %0d host credits, actual %0d", test_name, queue_depth,
                     host_credits);
        end
        $display("results %0d, pushes %0d, register reads %0d, errors %0d",
                 results, pushes, reads, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== source/mul_coproc_top.sv ====
// multiply coprocessor top, command queue to multiply unit to result port
`timescale 1ns/1ps

module mul_coproc_top import mul_pkg::*; #(
    parameter int data_width  = 16,
    parameter int queue_depth = 4,
    parameter int rsp_credits = 2
) (
    input  logic                        clk,
    input  logic                        reset,
    // host commands
    input  logic                        cmd_push,
    input  logic [op_width-1:0]         cmd_op,
    input  logic [data_width-1:0]       cmd_a,
    input  logic [data_width-1:0]       cmd_b,
    output logic                        cmd_credit,
    // consumer results
    output logic                        rsp_valid,
    output logic [data_width-1:0]       rsp_data,
    input  logic                        rsp_credit,
    // registers
    input  logic                        csr_write,
    input  logic                        csr_read,
    input  logic [csr_addr_width-1:0]   csr_addr,
    input  logic [data_width-1:0]       csr_wdata,
    output logic [data_width-1:0]       csr_rdata
);

    localparam int level_width = $clog2(queue_depth + 1);

    logic                      enable;
    logic                      sent;
    logic [level_width-1:0]    level;

    // queue head to multiply unit
    logic                      head_valid;
    logic                      head_ready;
    logic [op_width-1:0]       head_op;
    logic [data_width-1:0]     head_a;
    logic [data_width-1:0]     head_b;

    // product to result port
    logic                      prod_valid;
    logic                      prod_ready;
    logic [op_width-1:0]       prod_op;
    logic [2*data_width-1:0]   prod_data;

    cmd_queue #(
        .data_width  (data_width),
        .queue_depth (queue_depth)
    ) u_queue (
        .clk        (clk),
        .reset      (reset),
        .push       (cmd_push),
        .op         (cmd_op),
        .a          (cmd_a),
        .b          (cmd_b),
        .credit     (cmd_credit),
        .enable     (enable),
        .head_valid (head_valid),
        .head_ready (head_ready),
        .head_op    (head_op),
        .head_a     (head_a),
        .head_b     (head_b),
        .level      (level)
    );

    mul_unit #(
        .data_width (data_width)
    ) u_mul (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (head_valid),
        .in_ready    (head_ready),
        .in_op       (head_op),
        .in_a        (head_a),
        .in_b        (head_b),
        .out_valid   (prod_valid),
        .out_ready   (prod_ready),
        .out_op      (prod_op),
        .out_product (prod_data)
    );

    result_port #(
        .data_width  (data_width),
        .rsp_credits (rsp_credits)
    ) u_rsp (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (prod_valid),
        .in_ready   (prod_ready),
        .in_op      (prod_op),
        .in_product (prod_data),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_credit (rsp_credit),
        .sent       (sent)
    );

    mul_csr #(
        .data_width  (data_width),
        .queue_depth (queue_depth)
    ) u_csr (
        .clk       (clk),
        .reset     (reset),
        .csr_write (csr_write),
        .csr_read  (csr_read),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .enable    (enable),
        .sent      (sent),
        .level     (level)
    );

endmodule

// ==== source/mul_csr.sv ====
// register block with enable, result count clear, result count and queue level
`timescale 1ns/1ps

module mul_csr import mul_pkg::*; #(
    parameter int data_width  = 16,
    parameter int queue_depth = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               csr_write,
    input  logic                               csr_read,
    input  logic [csr_addr_width-1:0]          csr_addr,
    input  logic [data_width-1:0]              csr_wdata,
    output logic [data_width-1:0]              csr_rdata,
    output logic                               enable,
    input  logic                               sent,
    input  logic [$clog2(queue_depth+1)-1:0]   level
);

    logic                    ctrl_write;
    logic                    clear_count;
    logic [data_width-1:0]   count;

    assign ctrl_write  = csr_write && (csr_addr == csr_ctrl_addr);
    assign clear_count = ctrl_write && csr_wdata[1];

    // ------------------------------------------------------------------------
    // control and counter
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b0;
            count  <= '0;
        end else begin
            if (ctrl_write) begin
                enable <= csr_wdata[0];
            end
            // clear wins over a result in the same cycle
            if (clear_count) begin
                count <= '0;
            end else if (sent) begin
                count <= count + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // registered read mux
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (csr_read) begin
            case (csr_addr)
                csr_ctrl_addr:  csr_rdata <= data_width'(enable);
                csr_count_addr: csr_rdata <= count;
                csr_level_addr: csr_rdata <= data_width'(level);
                default:        csr_rdata <= '0;
            endcase
        end
    end

endmodule

// ==== source/result_port.sv ====
// result port, sends the selected product half against consumer credits
`timescale 1ns/1ps

module result_port import mul_pkg::*; #(
    parameter int data_width  = 16,
    parameter int rsp_credits = 2
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [op_width-1:0]       in_op,
    input  logic [2*data_width-1:0]   in_product,
    output logic                      rsp_valid,
    output logic [data_width-1:0]     rsp_data,
    input  logic                      rsp_credit,
    output logic                      sent
);

    localparam int credit_width = $clog2(rsp_credits + 1);

    logic                      held_valid;
    logic [op_width-1:0]       held_op;
    logic [2*data_width-1:0]   held_product;
    logic [credit_width-1:0]   credits;

    assign in_ready  = !held_valid;
    assign rsp_valid = held_valid && (credits != '0);
    assign sent      = rsp_valid;
    assign rsp_data  = held_op[op_high_bit] ? held_product[2*data_width-1:data_width]
                                            : held_product[data_width-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
            credits    <= credit_width'(rsp_credits);
        end else begin
            if (in_valid && in_ready) begin
                held_valid <= 1'b1;
            end else if (rsp_valid) begin
                held_valid <= 1'b0;
            end
            case ({rsp_credit, rsp_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held_op      <= in_op;
            held_product <= in_product;
        end
    end

endmodule

// ==== source/mul_unit.sv ====
// multiply unit, signed operand handling around the shift-add core
`timescale 1ns/1ps

module mul_unit import mul_pkg::*; #(
    parameter int data_width = 16
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [op_width-1:0]       in_op,
    input  logic [data_width-1:0]     in_a,
    input  logic [data_width-1:0]     in_b,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [op_width-1:0]       out_op,
    output logic [2*data_width-1:0]   out_product
);

    logic                      a_neg;
    logic                      b_neg;
    logic                      stage_valid;
    logic [data_width-1:0]     stage_a;
    logic [data_width-1:0]     stage_b;
    logic                      stage_neg;
    logic [op_width-1:0]       stage_op;
    logic                      core_ready;
    logic                      core_valid;
    logic                      core_take;
    logic [2*data_width-1:0]   core_product;
    logic                      core_neg;
    logic [op_width-1:0]       core_op;

    assign a_neg = in_op[op_signed_bit] && in_a[data_width-1];
    assign b_neg = in_op[op_signed_bit] && in_b[data_width-1];

    // stage drains into the core on the same edge it can refill
    assign in_ready  = !stage_valid || core_ready;
    assign core_take = core_valid && (!out_valid || out_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            if (in_valid && in_ready) begin
                stage_valid <= 1'b1;
            end else if (core_ready) begin
                stage_valid <= 1'b0;
            end
            if (core_take) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // magnitudes in, sign fixed on the way out
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            stage_a   <= a_neg ? -in_a : in_a;
            stage_b   <= b_neg ? -in_b : in_b;
            stage_neg <= a_neg ^ b_neg;
            stage_op  <= in_op;
        end
        if (stage_valid && core_ready) begin
            core_neg <= stage_neg;
            core_op  <= stage_op;
        end
        if (core_take) begin
            out_product <= core_neg ? -core_product : core_product;
            out_op      <= core_op;
        end
    end

    mul_shift_add #(
        .data_width (data_width)
    ) u_core (
        .clk       (clk),
        .reset     (reset),
        .s_a       (stage_a),
        .s_b       (stage_b),
        .s_valid   (stage_valid),
        .s_ready   (core_ready),
        .m_product (core_product),
        .m_valid   (core_valid),
        .m_ready   (!out_valid || out_ready)
    );

endmodule

// ==== source/mul_shift_add.sv ====
// unsigned multicycle shift-add multiplier, one cycle per significant multiplier bit
`timescale 1ns/1ps

module mul_shift_add #(
    parameter int data_width = 16
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [data_width-1:0]     s_a,
    input  logic [data_width-1:0]     s_b,
    input  logic                      s_valid,
    output logic                      s_ready,
    output logic [2*data_width-1:0]   m_product,
    output logic                      m_valid,
    input  logic                      m_ready
);

    logic                      busy;
    logic                      accept;
    logic [2*data_width-1:0]   mcand;
    logic [data_width-1:0]     mplier;
    logic [2*data_width-1:0]   acc;

    assign accept    = s_valid && s_ready;
    assign m_product = acc;

    // ------------------------------------------------------------------------
    // handshake control
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            s_ready <= 1'b0;
            m_valid <= 1'b0;
        end else begin
            if (!busy && !m_valid) begin
                s_ready <= 1'b1;
            end
            // product taken, idle again
            if (m_valid && m_ready) begin
                m_valid <= 1'b0;
                s_ready <= 1'b1;
            end
            if (accept) begin
                busy    <= 1'b1;
                s_ready <= 1'b0;
            end else if (busy && mplier == '0) begin
                busy    <= 1'b0;
                m_valid <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // shift-add datapath
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (accept) begin
            mcand  <= {{data_width{1'b0}}, s_a};
            mplier <= s_b;
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mplier <= mplier >> 1;
            mcand  <= mcand << 1;
        end
    end

endmodule

// ==== source/cmd_queue.sv ====
// command queue, a circular buffer of multiply commands returning a credit per pop
`timescale 1ns/1ps

module cmd_queue import mul_pkg::*; #(
    parameter int data_width  = 16,
    parameter int queue_depth = 4
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 push,
    input  logic [op_width-1:0]                  op,
    input  logic [data_width-1:0]                a,
    input  logic [data_width-1:0]                b,
    output logic                                 credit,
    input  logic                                 enable,
    output logic                                 head_valid,
    input  logic                                 head_ready,
    output logic [op_width-1:0]                  head_op,
    output logic [data_width-1:0]                head_a,
    output logic [data_width-1:0]                head_b,
    output logic [$clog2(queue_depth+1)-1:0]     level
);

    localparam int ptr_width   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int entry_width = op_width + 2 * data_width;

    logic [entry_width-1:0] mem [queue_depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic                   pop;

    // head only shown while the coprocessor is enabled
    assign head_valid = enable && (level != '0);
    assign pop        = head_valid && head_ready;
    assign credit     = pop;

    assign {head_op, head_a, head_b} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {op, a, b};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_width'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

// ==== source/mul_pkg.sv ====
// multiply coprocessor shared constants for operation codes and register map
package mul_pkg;

    // ------------------------------------------------------------------------
    // operation code
    // ------------------------------------------------------------------------

    localparam int op_width = 2;

    // both operands are two's complement
    localparam int unsigned op_signed_bit = 0;
    // return upper half of the product
    localparam int unsigned op_high_bit = 1;

    // ------------------------------------------------------------------------
    // register map
    // ------------------------------------------------------------------------

    localparam int csr_addr_width = 2;

    // bit 0 enable, bit 1 clear count (write only)
    localparam logic [csr_addr_width-1:0] csr_ctrl_addr = 2'd0;
    // completed results, read only
    localparam logic [csr_addr_width-1:0] csr_count_addr = 2'd1;
    // command queue occupancy, read only
    localparam logic [csr_addr_width-1:0] csr_level_addr = 2'd2;

endpackage
